//--- flist.f
ql_clock_pkg.sv
ql_bus_pkg.sv
ql_clock_enables.sv
ql_memory_map.sv
ql_bus_steer.sv
ql_bus_core.sv
ql_bus_props.sv
tb_ql_bus_core.sv

//--- Bender.yml
package:
  name: ql_bus_core

sources:
  - ql_clock_pkg.sv
  - ql_bus_pkg.sv
  - ql_clock_enables.sv
  - ql_memory_map.sv
  - ql_bus_steer.sv
  - ql_bus_core.sv
  - target: test
    files:
      - ql_bus_props.sv
      - tb_ql_bus_core.sv

//--- tb_ql_bus_core.sv
// ====================
// QL bus core testbench
// Enable counts, memory map table with
// random SDRAM DTACK and GoldCard shadow
// ====================

`timescale 1ns/1ps

module tb_ql_bus_core;

	import ql_clock_pkg::*;
	import ql_bus_pkg::*;

	typedef struct packed
	{
		ram_cfg_e    cfg;
		logic [2:0]  bus;	// rw, uds, lds
		logic [23:0] addr;
		logic [15:0] data;	// Expected data
		logic [3:0]  rsp;	// DTACK from SDRAM, oe, wr, io_sel
		logic [22:0] waddr;	// SDRAM word address when oe or wr
	} row_t;

	localparam int NUM_ROWS       = 24;
	localparam int ROW_CYCLES     = 25;	// Request plus SDRAM wait states
	localparam int NUM_RESETS     = 9;	// Each takes 5 cycles
	localparam int TIMEOUT_CYCLES = 1280 + 4 * 1024 + NUM_RESETS * 5
		+ NUM_ROWS * ROW_CYCLES + 20;

	logic        clk_sys;
	logic        reset;
	cpu_speed_e  cpu_speed;
	ram_cfg_e    ram_cfg_sel;
	ql_cpu_req_t cpu_req;
	logic [15:0] rom_data;
	logic [15:0] gc_rom_data;
	logic [15:0] sdram_data;
	logic [15:0] io_data;
	logic        sdram_dtack;
	ql_ce_t      ce;
	ql_cpu_rsp_t cpu_rsp;
	ql_mem_req_t mem_req;
	logic        io_sel;
	row_t        rows [NUM_ROWS];
	logic [31:0] lcg_state;
	int          cycles = 0;

	ql_bus_core ql_bus_core_inst
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_speed   (cpu_speed),
		.ram_cfg_sel (ram_cfg_sel),
		.cpu_req     (cpu_req),
		.rom_data    (rom_data),
		.gc_rom_data (gc_rom_data),
		.sdram_data  (sdram_data),
		.io_data     (io_data),
		.sdram_dtack (sdram_dtack),
		.ce          (ce),
		.cpu_rsp     (cpu_rsp),
		.mem_req     (mem_req),
		.io_sel      (io_sel)
	);

	bind ql_bus_core ql_bus_props ql_bus_props_inst
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce      (ce),
		.cpu_req (cpu_req),
		.cpu_rsp (cpu_rsp),
		.mem_req (mem_req),
		.io_sel  (io_sel)
	);

	initial
	begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;	// 100 ns period
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		abort_run();
	endtask

	// Hang guard
	always @(posedge clk_sys)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: no DTACK or end of tests after %0d cycles", cycles);
			abort_run();
		end
	end

	// Stop at the first failure of a bound property
	always @(ql_bus_core_inst.ql_bus_props_inst.fail_count)
	begin
		if (ql_bus_core_inst.ql_bus_props_inst.fail_count != 0)
		begin
			$display("bound property failed at %0t ns", $time);
			abort_run();
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Four reset cycles latch the RAM size
	task automatic apply_reset(input ram_cfg_e cfg);
		@(posedge clk_sys);
		#5;
		reset       = 1'b1;
		ram_cfg_sel = cfg;
		cpu_req     = '0;
		repeat (4) @(posedge clk_sys);
		#5;
		reset       = 1'b0;
		ram_cfg_sel = ram_cfg_e'(~cfg);	// Another size that the DUT ignores
	endtask

	task automatic count_enables(input int n, output int n_bus, output int n_131k,
		output int n_vid);
		logic next_n;	// Next bus pulse must be phi2
		n_bus  = 0;
		n_131k = 0;
		n_vid  = 0;
		next_n = 1'b0;
		repeat (n)
		begin
			@(posedge clk_sys);
			#5;
			if (ce.ce_bus_p || ce.ce_bus_n)
			begin
				assert (ce.ce_bus_n == next_n)
				else
				begin
					$display("bus phase pulses out of order at %0t ns", $time);
					abort_run();
				end
				next_n = !next_n;
				n_bus++;
			end
			n_131k += ce.ce_131k;
			n_vid  += ce.ce_vid;
		end
	endtask

	// Hold the request until DTACK with a new random SDRAM DTACK each cycle
	task automatic run_row(input row_t r, input int idx);
		logic done;
		logic sd;
		logic oe;
		logic wr;
		logic io;
		{sd, oe, wr, io} = r.rsp;
		cpu_req.as        = 1'b1;
		{cpu_req.rw, cpu_req.uds, cpu_req.lds} = r.bus;
		cpu_req.addr.flat = r.addr;
		do
		begin
			lcg_state   = lcg_next(lcg_state);
			sdram_dtack = lcg_state[16];
			@(negedge clk_sys);	// Combinational outputs settled
			assert (cpu_rsp.data == r.data)
				else value_error($sformatf("row %0d data", idx), cpu_rsp.data, r.data);
			assert (cpu_rsp.dtack == (sd ? sdram_dtack : 1'b1))
				else value_error($sformatf("row %0d dtack", idx), cpu_rsp.dtack,
					sd ? sdram_dtack : 1'b1);
			assert ({mem_req.sdram_oe, mem_req.sdram_wr, io_sel} == {oe, wr, io})
				else value_error($sformatf("row %0d oe/wr/io_sel", idx),
					{mem_req.sdram_oe, mem_req.sdram_wr, io_sel}, {oe, wr, io});
			if (oe || wr)
			begin
				assert (mem_req.sdram_addr == r.waddr)
					else value_error($sformatf("row %0d sdram_addr", idx),
						mem_req.sdram_addr, r.waddr);
			end
			done = cpu_rsp.dtack;
			@(posedge clk_sys);
			#5;
		end
		while (!done);
	endtask

	task automatic fill_table();
		// ==================== QL 128k wrapping at 256 KB
		rows[0]  = '{RAM_128K,  3'b111, 24'h000100, 16'hA001, 4'b0000, 23'h000000};
		rows[1]  = '{RAM_128K,  3'b111, 24'h020000, 16'hC003, 4'b1100, 23'h010000};
		rows[2]  = '{RAM_128K,  3'b111, 24'h018000, 16'hD004, 4'b0001, 23'h000000};
		rows[3]  = '{RAM_128K,  3'b111, 24'h060000, 16'hC003, 4'b1100, 23'h010000};	// Alias
		rows[4]  = '{RAM_128K,  3'b011, 24'h030000, 16'hC003, 4'b1010, 23'h018000};
		rows[5]  = '{RAM_128K,  3'b111, 24'h010000, 16'hFFFF, 4'b0000, 23'h000000};
		rows[6]  = '{RAM_128K,  3'b101, 24'h03FFFE, 16'hC003, 4'b1100, 23'h01FFFF};	// Odd byte
		// ==================== QL 640k and 896k
		rows[7]  = '{RAM_640K,  3'b111, 24'h080000, 16'hC003, 4'b1100, 23'h040000};
		rows[8]  = '{RAM_640K,  3'b111, 24'h0C0000, 16'hFFFF, 4'b0000, 23'h000000};
		rows[9]  = '{RAM_640K,  3'b111, 24'h120000, 16'hC003, 4'b1100, 23'h010000};
		rows[10] = '{RAM_640K,  3'b111, 24'h00C000, 16'hA001, 4'b0000, 23'h000000};
		rows[11] = '{RAM_896K,  3'b111, 24'h0C0000, 16'hC003, 4'b1100, 23'h060000};
		rows[12] = '{RAM_896K,  3'b011, 24'h1C0000, 16'hC003, 4'b1010, 23'h060000};
		rows[13] = '{RAM_896K,  3'b111, 24'h018002, 16'hD004, 4'b0001, 23'h000000};
		rows[14] = '{RAM_896K,  3'b111, 24'h01C000, 16'hFFFF, 4'b0000, 23'h000000};	// No GoldCard
		// ==================== GoldCard with shadow on then off
		rows[15] = '{RAM_4096K, 3'b111, 24'h000000, 16'hB002, 4'b0000, 23'h000000};
		rows[16] = '{RAM_4096K, 3'b011, 24'h000100, 16'hB002, 4'b1010, 23'h000080};	// Fill copy
		rows[17] = '{RAM_4096K, 3'b010, 24'h01C060, 16'hFFFF, 4'b0000, 23'h000000};
		rows[18] = '{RAM_4096K, 3'b111, 24'h000000, 16'hC003, 4'b1100, 23'h000000};
		rows[19] = '{RAM_4096K, 3'b010, 24'h01C064, 16'hFFFF, 4'b0000, 23'h000000};
		rows[20] = '{RAM_4096K, 3'b111, 24'h000000, 16'hB002, 4'b0000, 23'h000000};
		rows[21] = '{RAM_4096K, 3'b111, 24'h200000, 16'hC003, 4'b1100, 23'h100000};
		rows[22] = '{RAM_4096K, 3'b111, 24'h900000, 16'hC003, 4'b1100, 23'h080000};	// 8 MB wrap
		rows[23] = '{RAM_4096K, 3'b111, 24'h018000, 16'hD004, 4'b0001, 23'h000000};
	endtask

	initial
	begin
		int n_bus;
		int n_131k;
		int n_vid;
		int step;
		int exp_bus;
		reset       = 1'b1;
		cpu_speed   = SPEED_QL;
		ram_cfg_sel = RAM_128K;
		cpu_req     = '0;
		rom_data    = 16'hA001;
		gc_rom_data = 16'hB002;
		sdram_data  = 16'hC003;
		io_data     = 16'hD004;
		sdram_dtack = 1'b0;
		lcg_state   = 32'h2512;
		fill_table();

		// ==================== Pixel and 131 kHz ticks
		apply_reset(RAM_128K);
		count_enables(1280, n_bus, n_131k, n_vid);
		assert (n_vid == 160) else value_error("ce_vid count", n_vid, 160);
		assert (n_131k == 2) else value_error("ce_131k count", n_131k, 2);

		// Bus phases per speed within one of floor(N * step / 65536)
		for (int s = 0; s < 4; s++)
		begin
			cpu_speed = cpu_speed_e'(s);
			case (cpu_speed)
				SPEED_QL: step = FRACT_BUS_QL;
				SPEED_16: step = FRACT_BUS_16;
				SPEED_24: step = FRACT_BUS_24;
				default:  step = FRACT_BUS_FULL;
			endcase
			exp_bus = (1024 * step) / 65536;
			apply_reset(RAM_128K);
			count_enables(1024, n_bus, n_131k, n_vid);
			assert (n_bus >= exp_bus - 1 && n_bus <= exp_bus + 1)
				else value_error($sformatf("bus pulses at speed %0d", s), n_bus, exp_bus);
		end

		// ==================== Memory map table
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			if (i == 0 || rows[i].cfg != rows[i - 1].cfg)
				apply_reset(rows[i].cfg);
			run_row(rows[i], i);
		end

		cpu_req           = '0;
		cpu_req.addr.flat = 24'h020000;	// RAM address with no strobe
		@(negedge clk_sys);
		assert ({mem_req.sdram_oe, mem_req.sdram_wr, io_sel} == 3'b000)
			else value_error("idle oe/wr/io_sel", {mem_req.sdram_oe, mem_req.sdram_wr, io_sel}, 0);

		$display("Test passed");
		$finish;
	end

endmodule

//--- ql_bus_props.sv
// ====================
// QL bus core properties
// Enable exclusivity, idle strobes, DTACK
// ====================

`timescale 1ns/1ps

module ql_bus_props
(
	input logic                    clk_sys,
	input logic                    reset,
	input ql_clock_pkg::ql_ce_t    ce,
	input ql_bus_pkg::ql_cpu_req_t cpu_req,
	input ql_bus_pkg::ql_cpu_rsp_t cpu_rsp,
	input ql_bus_pkg::ql_mem_req_t mem_req,
	input logic                    io_sel
);

	int fail_count = 0;	// Failed assertions so far

	// Bus phases never overlap
	bus_phase_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce.ce_bus_p && ce.ce_bus_n))
		else
		begin
			fail_count++;
			$error("ce_bus_p and ce_bus_n high in the same cycle");
		end

	// No SDRAM or I/O strobe without address strobe
	idle_strobes: assert property (@(posedge clk_sys) disable iff (reset)
		!cpu_req.as |-> !mem_req.sdram_oe && !mem_req.sdram_wr && !io_sel)
		else
		begin
			fail_count++;
			$error("SDRAM or I/O strobe active while as is low");
		end

	// Accesses that skip SDRAM finish at once
	fast_dtack: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_req.as && (cpu_req.uds || cpu_req.lds)
		&& !mem_req.sdram_oe && !mem_req.sdram_wr |-> cpu_rsp.dtack)
		else
		begin
			fail_count++;
			$error("dtack low on an access that does not use SDRAM");
		end

endmodule

//--- ql_bus_core.sv
// ====================
// QL bus core
// Clock enables, memory map and bus steering
// ====================

`timescale 1ns/1ps

module ql_bus_core
(
	input  logic                     clk_sys,
	input  logic                     reset,
	input  ql_clock_pkg::cpu_speed_e cpu_speed,
	input  ql_bus_pkg::ram_cfg_e     ram_cfg_sel,
	input  ql_bus_pkg::ql_cpu_req_t  cpu_req,
	input  logic [15:0]              rom_data,
	input  logic [15:0]              gc_rom_data,
	input  logic [15:0]              sdram_data,
	input  logic [15:0]              io_data,
	input  logic                     sdram_dtack,
	output ql_clock_pkg::ql_ce_t     ce,
	output ql_bus_pkg::ql_cpu_rsp_t  cpu_rsp,
	output ql_bus_pkg::ql_mem_req_t  mem_req,
	output logic                     io_sel
);

	import ql_bus_pkg::*;

	ql_addr_u   addr;	// Wrapped address
	ql_region_t region;

	ql_clock_enables ql_clock_enables_inst
	(
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_speed (cpu_speed),
		.ce        (ce)
	);

	ql_memory_map ql_memory_map_inst
	(
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ram_cfg_sel (ram_cfg_sel),
		.cpu_req     (cpu_req),
		.addr        (addr),
		.region      (region)
	);

	ql_bus_steer ql_bus_steer_inst
	(
		.cpu_req     (cpu_req),
		.addr        (addr),
		.region      (region),
		.rom_data    (rom_data),
		.gc_rom_data (gc_rom_data),
		.sdram_data  (sdram_data),
		.io_data     (io_data),
		.sdram_dtack (sdram_dtack),
		.cpu_rsp     (cpu_rsp),
		.mem_req     (mem_req),
		.io_sel      (io_sel)
	);

endmodule

//--- ql_bus_steer.sv
// ====================
// QL bus steering
// Read data mux, DTACK and SDRAM strobes
// ====================

`timescale 1ns/1ps

module ql_bus_steer
(
	input  ql_bus_pkg::ql_cpu_req_t cpu_req,
	input  ql_bus_pkg::ql_addr_u    addr,
	input  ql_bus_pkg::ql_region_t  region,
	input  logic [15:0]             rom_data,
	input  logic [15:0]             gc_rom_data,
	input  logic [15:0]             sdram_data,
	input  logic [15:0]             io_data,
	input  logic                    sdram_dtack,
	output ql_bus_pkg::ql_cpu_rsp_t cpu_rsp,
	output ql_bus_pkg::ql_mem_req_t mem_req,
	output logic                    io_sel
);

	import ql_bus_pkg::*;

	logic        cpu_rd;
	logic        cpu_wr;
	logic [15:0] gc_dout_boot;
	logic [15:0] gc_dout_shadow;
	logic [15:0] ql_dout;
	logic        sdram_access;	// Needs the SDRAM handshake

	assign cpu_rd = cpu_req.as && cpu_req.rw && (cpu_req.uds || cpu_req.lds);
	assign cpu_wr = cpu_req.as && !cpu_req.rw && (cpu_req.uds || cpu_req.lds);

	// ==================== Read data
	// GoldCard boot, its own ROM at 0
	assign gc_dout_boot =
		region.rom         ? gc_rom_data :
		region.gc_boot_rom ? gc_rom_data :	// Second copy at $40000
		region.gc_os_rom   ? rom_data :
		region.ram         ? sdram_data :
		BUS_IDLE_DATA;

	// GoldCard with shadow, OS from RAM
	assign gc_dout_shadow =
		region.os_rom    ? sdram_data :
		region.ext_rom   ? rom_data :
		region.gc_os_rom ? rom_data :
		region.ram       ? sdram_data :
		BUS_IDLE_DATA;

	assign ql_dout =
		region.rom ? rom_data :		// OS plus ext ROM
		region.ram ? sdram_data :
		BUS_IDLE_DATA;

	always_comb
	begin
		if (region.ql_io)
			cpu_rsp.data = io_data;		// Always mapped
		else if (region.gc_en)
			cpu_rsp.data = region.shadow_on ? gc_dout_shadow : gc_dout_boot;
		else
			cpu_rsp.data = ql_dout;
	end

	// ==================== Handshake and SDRAM
	assign sdram_access  = region.ram || region.shadow_read || region.shadow_write;
	assign cpu_rsp.dtack = sdram_access ? sdram_dtack : 1'b1;

	assign mem_req.sdram_addr = addr.flat[23:1];
	assign mem_req.sdram_oe   = cpu_rd && (region.ram || region.shadow_read);
	assign mem_req.sdram_wr   = cpu_req.as && !cpu_req.rw && (region.ram || region.shadow_write);

	assign io_sel = (cpu_rd || cpu_wr) && region.ql_io;	// ZX8302/mouse space

endmodule

//--- ql_memory_map.sv
// ====================
// QL memory map
// RAM size latch, address wrap, region decode
// and the GoldCard ROM shadow register
// ====================

`timescale 1ns/1ps

module ql_memory_map
(
	input  logic                     clk_sys,
	input  logic                     reset,
	input  ql_bus_pkg::ram_cfg_e     ram_cfg_sel,
	input  ql_bus_pkg::ql_cpu_req_t  cpu_req,
	output ql_bus_pkg::ql_addr_u     addr,
	output ql_bus_pkg::ql_region_t   region
);

	import ql_bus_pkg::*;

	ram_cfg_e    ram_cfg;
	logic [23:0] addr_mask;
	logic        cpu_rd;
	logic        cpu_wr;
	logic        gc_en;
	logic        ql_io;
	logic        gc_io;
	logic        bram;
	logic        xram;
	logic        gc_ram;
	logic        rom;
	logic        ext_rom;
	logic        os_rom;
	logic        rom_shadow;

	// Size picked up only while reset is high
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			ram_cfg <= ram_cfg_sel;
	end

	assign gc_en = (ram_cfg == RAM_4096K);

	always_comb
	begin
		case (ram_cfg)
			RAM_128K:           addr_mask = MASK_128K;
			RAM_640K, RAM_896K: addr_mask = MASK_1M;
			default:            addr_mask = MASK_8M;	// 4 MB plus GoldCard space
		endcase
	end

	// A0 from the strobes, lower byte only means odd
	assign addr.flat = {cpu_req.addr.flat[23:1], !cpu_req.uds && cpu_req.lds} & addr_mask;

	assign cpu_rd = cpu_req.as && cpu_req.rw && (cpu_req.uds || cpu_req.lds);
	assign cpu_wr = cpu_req.as && !cpu_req.rw && (cpu_req.uds || cpu_req.lds);

	// ==================== QL regions
	assign ql_io   = (addr.flat[23:14] == QL_IO_BASE[23:14]);
	assign bram    = (addr.flat[23:17] == 7'h01);	// 128k base $20000-$3FFFF
	assign rom     = (addr.f.bank == 8'h00);			// 64k ROM space
	assign ext_rom = (addr.flat[23:14] == 10'h003);	// $C000-$FFFF
	assign os_rom  = rom && !ext_rom;

	always_comb
	begin
		case (ram_cfg)
			RAM_640K:  xram = (addr.flat[23:20] == 4'h0) && ^addr.flat[19:18];	// $40000-$BFFFF
			RAM_896K:  xram = (addr.flat[23:20] == 4'h0) && |addr.flat[19:18];	// $40000-$FFFFF
			RAM_4096K: xram = (addr.flat[23:22] == 2'b00) && |addr.flat[21:18];	// to $3FFFFF
			default:   xram = 1'b0;
		endcase
	end

	// ==================== GoldCard regions
	assign gc_io  = gc_en && (addr.flat[23:8] == GC_IO_PAGE);
	assign gc_ram = gc_en && ((addr.flat[23:15] == 9'h002)		// 32k at $10000
		|| ((addr.flat[23:14] == 10'h007) && !gc_io));		// 16k at $1C100

	// Shadow on/off by upper byte writes to GoldCard registers
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			rom_shadow <= 1'b0;
		else if (gc_io && cpu_wr && cpu_req.uds && !cpu_req.lds)
		begin
			if (addr.f.offset == GC_SHADOW_ON)
				rom_shadow <= 1'b1;
			else if (addr.f.offset == GC_SHADOW_OFF)
				rom_shadow <= 1'b0;
		end
	end

	always_comb
	begin
		region             = '0;
		region.ql_io       = ql_io;
		region.ram         = bram || xram || gc_ram;
		region.rom         = rom;
		region.ext_rom     = ext_rom;
		region.os_rom      = os_rom;
		region.gc_io       = gc_io;
		region.gc_boot_rom = gc_en && (addr.f.bank == GC_BOOT_BANK);
		region.gc_os_rom   = gc_en && (addr.f.bank == GC_OS_BANK);
		region.gc_en       = gc_en;
		region.shadow_on   = rom_shadow;
		region.shadow_read = cpu_rd && os_rom && rom_shadow;	// OS ROM from RAM copy
		// OS ROM writes fill the RAM copy before it is switched on
		region.shadow_write = gc_en && cpu_req.as && !cpu_req.rw && os_rom && !rom_shadow;
	end

endmodule

//--- ql_clock_enables.sv
// ====================
// QL clock enables
// Fractional CPU bus phases, 131 kHz tick
// and pixel tick, all registered
// ====================

`timescale 1ns/1ps

module ql_clock_enables
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  ql_clock_pkg::cpu_speed_e cpu_speed,
	output ql_clock_pkg::ql_ce_t     ce
);

	import ql_clock_pkg::*;

	logic [FRACT_WIDTH:0]   fract_bus;	// Step for the selected speed
	logic [FRACT_WIDTH:0]   bus_sum;
	logic [FRACT_WIDTH-1:0] acc;
	logic                   bus_carry;
	logic                   bus_pol;	// Next pulse goes to n when set
	logic [9:0]             div_131k;
	logic [3:0]             div_vid;

	always_comb
	begin
		case (cpu_speed)
			SPEED_QL:   fract_bus = FRACT_BUS_QL;
			SPEED_16:   fract_bus = FRACT_BUS_16;
			SPEED_24:   fract_bus = FRACT_BUS_24;
			default:    fract_bus = FRACT_BUS_FULL;
		endcase
	end

	assign bus_sum   = {1'b0, acc} + fract_bus;
	assign bus_carry = bus_sum[FRACT_WIDTH];	// One bus phase per carry

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			acc      <= '0;
			bus_pol  <= 1'b0;
			div_131k <= '0;
			div_vid  <= '0;
			ce       <= '0;
		end
		else
		begin
			acc         <= bus_sum[FRACT_WIDTH-1:0];
			bus_pol     <= bus_pol ^ bus_carry;
			ce.ce_bus_p <= bus_carry && !bus_pol;
			ce.ce_bus_n <= bus_carry && bus_pol;

			// Wrap counters, pulse on zero
			div_131k   <= (div_131k == DIV_131K - 10'd1) ? 10'd0 : div_131k + 10'd1;
			ce.ce_131k <= (div_131k == 10'd0);
			div_vid    <= (div_vid == DIV_VID - 4'd1) ? 4'd0 : div_vid + 4'd1;
			ce.ce_vid  <= (div_vid == 4'd0);
		end
	end

endmodule

//--- ql_bus_pkg.sv
// ====================
// QL bus package
// CPU request/response, address views,
// region flags and the memory map
// ====================

package ql_bus_pkg;

	// Address seen as bank/page/offset bytes
	typedef struct packed
	{
		logic [7:0] bank;	// A23..A16
		logic [7:0] page;	// A15..A8
		logic [7:0] offset;	// A7..A0, GoldCard register select
	} ql_addr_fields_t;

	typedef union packed
	{
		logic [23:0]     flat;
		ql_addr_fields_t f;
	} ql_addr_u;

	// 68008-style bus request, strobes active high
	typedef struct packed
	{
		logic     as;
		logic     rw;	// High for read
		logic     uds;
		logic     lds;
		ql_addr_u addr;	// Bit 0 ignored, rebuilt from strobes
	} ql_cpu_req_t;

	typedef struct packed
	{
		logic [15:0] data;
		logic        dtack;
	} ql_cpu_rsp_t;

	typedef enum logic [1:0]
	{
		RAM_128K  = 2'd0,
		RAM_640K  = 2'd1,
		RAM_896K  = 2'd2,
		RAM_4096K = 2'd3	// Also turns on GoldCard mode
	} ram_cfg_e;

	// Decoded region of the current access
	typedef struct packed
	{
		logic ql_io;
		logic ram;		// Any RAM, base, extended or GoldCard
		logic rom;
		logic ext_rom;
		logic os_rom;
		logic gc_io;
		logic gc_boot_rom;
		logic gc_os_rom;
		logic gc_en;
		logic shadow_on;
		logic shadow_read;
		logic shadow_write;
	} ql_region_t;

	typedef struct packed
	{
		logic [22:0] sdram_addr;	// Word address
		logic        sdram_oe;
		logic        sdram_wr;
	} ql_mem_req_t;

	// ==================== Memory map
	localparam logic [23:0] MASK_128K = 24'h03FFFF;	// Wrap at 256 KB
	localparam logic [23:0] MASK_1M   = 24'h0FFFFF;
	localparam logic [23:0] MASK_8M   = 24'h7FFFFF;

	localparam logic [7:0] GC_SHADOW_ON  = 8'h60;	// glo_rena
	localparam logic [7:0] GC_SHADOW_OFF = 8'h64;	// glo_rdis

	localparam logic [23:0] QL_IO_BASE   = 24'h018000;	// $18000-$1BFFF
	localparam logic [15:0] GC_IO_PAGE   = 16'h01C0;	// $1C000-$1C0FF
	localparam logic [7:0]  GC_BOOT_BANK = 8'h04;
	localparam logic [7:0]  GC_OS_BANK   = 8'h40;

	localparam logic [15:0] BUS_IDLE_DATA = 16'hFFFF;	// Unmapped reads

endpackage

//--- ql_clock_pkg.sv
// ====================
// QL clock package
// CPU speed select, divider constants
// and the bundle of clock enables
// ====================

package ql_clock_pkg;

	// CPU bus speed, as picked from the menu
	typedef enum logic [1:0]
	{
		SPEED_QL   = 2'd0,	// Original 7.5 MHz bus
		SPEED_16   = 2'd1,
		SPEED_24   = 2'd2,
		SPEED_FULL = 2'd3	// One bus phase per clk_sys
	} cpu_speed_e;

	// Accumulator steps, clk_sys at 84 MHz
	localparam logic [16:0] FRACT_BUS_QL   = 17'd11702;	// ~15 MHz phase rate
	localparam logic [16:0] FRACT_BUS_16   = 17'd24966;	// ~32 MHz
	localparam logic [16:0] FRACT_BUS_24   = 17'd37449;	// ~48 MHz
	localparam logic [16:0] FRACT_BUS_FULL = 17'd65536;	// Carry every cycle
	localparam int          FRACT_WIDTH    = 16;

	localparam logic [9:0] DIV_131K = 10'd640;	// 131.25 kHz refresh/RTC tick
	localparam logic [3:0] DIV_VID  = 4'd8;		// 10.5 MHz pixel tick

	// One-cycle enables, all in clk_sys
	typedef struct packed
	{
		logic ce_bus_p;	// CPU phi1
		logic ce_bus_n;	// CPU phi2
		logic ce_131k;
		logic ce_vid;
	} ql_ce_t;

endpackage
